// ==== design/organ_pkg.sv ====
`default_nettype none

package organ_pkg;

  // ==========================================================
  // Notes
  // ==========================================================

  typedef enum logic [2:0] {
    do_lo,
    re,
    mi,
    fa,
    so,
    la,
    si,
    do_hi
  } note_e;

  // Frequencies in Hz, one per note
  localparam logic [31:0] note_freq_hz [0:7] = '{
    32'd523, 32'd587, 32'd659, 32'd698, 32'd783, 32'd880, 32'd987, 32'd1046
  };

  // Board switch order, not binary order
  localparam note_e note_code_map [0:7] = '{
    do_lo, re, mi, so, fa, la, si, do_hi
  };

  // ==========================================================
  // Text
  // ==========================================================

  typedef logic [7:0] char_t;

  typedef struct packed {
    char_t c0;
    char_t c1;
    char_t c2;
    char_t c3;
  } text4_t;

  localparam char_t char_space = 8'h20;
  localparam char_t char_a     = 8'h41;
  localparam char_t char_d     = 8'h44;
  localparam char_t char_e     = 8'h45;
  localparam char_t char_f     = 8'h46;
  localparam char_t char_h     = 8'h48;
  localparam char_t char_i     = 8'h49;
  localparam char_t char_l     = 8'h4C;
  localparam char_t char_m     = 8'h4D;
  localparam char_t char_n     = 8'h4E;
  localparam char_t char_o     = 8'h4F;
  localparam char_t char_r     = 8'h52;
  localparam char_t char_s     = 8'h53;

  localparam text4_t note_name [0:7] = '{
    '{char_d, char_o, char_space, char_space},
    '{char_r, char_e, char_space, char_space},
    '{char_m, char_i, char_space, char_space},
    '{char_f, char_a, char_space, char_space},
    '{char_s, char_o, char_space, char_space},
    '{char_l, char_a, char_space, char_space},
    '{char_s, char_i, char_space, char_space},
    '{char_d, char_o, char_h, char_space}
  };

  localparam text4_t text_blank = '{char_space, char_space, char_space, char_space};
  localparam text4_t text_on    = '{char_o, char_n, char_space, char_space};
  localparam text4_t text_off   = '{char_o, char_f, char_f, char_space};

  // ==========================================================
  // Board I/O and datapath types
  // ==========================================================

  typedef struct packed {
    logic       power;
    logic [2:0] note_code;
  } organ_sw_t;

  // All keys active low
  typedef struct packed {
    logic speed_up_n;
    logic speed_down_n;
    logic speed_reset_n;
  } key_n_t;

  typedef logic signed [7:0]  audio_t;
  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        rate_count_t;

  localparam audio_t audio_high = 8'sh7F;
  localparam audio_t audio_low  = 8'sh80;

  // 2 kHz sampling clock at 50 MHz
  localparam rate_count_t default_rate_count = 16'd12499;
  localparam speed_t      speed_step         = 16'sd100;

  // Segments active low, gfedcba
  typedef logic [6:0] seg7_t;

  typedef struct packed {
    seg7_t hex5;
    seg7_t hex4;
    seg7_t hex3;
    seg7_t hex2;
    seg7_t hex1;
    seg7_t hex0;
  } hex_bank_t;

  localparam seg7_t seg7_glyph [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

`default_nettype wire

// ==== design/note_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module note_select #(
  parameter int clk_hz = 50_000_000
) (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  organ_pkg::organ_sw_t sw,
  output logic [31:0]          half_period,
  output logic                 power,
  output organ_pkg::text4_t    note_text,
  output organ_pkg::text4_t    power_text
);

  organ_pkg::organ_sw_t sw_meta;
  organ_pkg::organ_sw_t sw_sync;
  organ_pkg::note_e     note;
  logic [31:0]          half_table [0:7];

  // Half period in clock cycles, fixed at elaboration
  for (genvar i = 0; i < 8; i++)
  begin : g_half
    localparam logic [31:0] half_cycles = clk_hz / (2 * organ_pkg::note_freq_hz[i]);
    assign half_table[i] = half_cycles;
  end

  // Two-stage switch synchronizer
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sw_meta <= '0;
      sw_sync <= '0;
    end
    else
    begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  assign note = organ_pkg::note_code_map[sw_sync.note_code];

  // Output register stage
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      half_period <= half_table[organ_pkg::do_lo];
      power       <= 1'b0;
      note_text   <= organ_pkg::text_blank;
      power_text  <= organ_pkg::text_off;
    end
    else
    begin
      half_period <= half_table[note];
      power       <= sw_sync.power;
      // Name blanked while the organ is off
      note_text   <= sw_sync.power ? organ_pkg::note_name[note] : organ_pkg::text_blank;
      power_text  <= sw_sync.power ? organ_pkg::text_on : organ_pkg::text_off;
    end
  end

endmodule

`default_nettype wire

// ==== design/tone_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tone_gen (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  logic [31:0]       half_period,
  input  logic              power,
  output organ_pkg::audio_t audio
);

  logic [31:0] cnt;
  logic [31:0] period_q;
  logic        wave;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt      <= '0;
      period_q <= '0;
      wave     <= 1'b0;
    end
    else
    begin
      period_q <= half_period;
      if (!power)
      begin
        cnt  <= '0;
        wave <= 1'b0;
      end
      else if (half_period != period_q)
      begin
        // New note, start the half period over
        cnt <= '0;
      end
      else if (cnt == half_period - 32'd1)
      begin
        cnt  <= '0;
        wave <= ~wave;
      end
      else
      begin
        cnt <= cnt + 32'd1;
      end
    end
  end

  // 1-bit wave to signed full-scale sample
  assign audio = (wave && power) ? organ_pkg::audio_high : organ_pkg::audio_low;

endmodule

`default_nettype wire

// ==== design/key_repeat.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_repeat #(
  parameter int repeat_cycles = 5_000_000
) (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  organ_pkg::key_n_t key_n,
  output logic              up_pulse,
  output logic              down_pulse,
  output logic              reset_pulse
);

  localparam int cnt_w = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;

  organ_pkg::key_n_t key_meta;
  organ_pkg::key_n_t key_sync;
  logic [cnt_w-1:0]  rep_cnt;
  logic              wrap;

  // Released keys read high, so sync stages reset to ones
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  // ==========================================================
  // Repeat interval
  // ==========================================================

  assign wrap = (rep_cnt == cnt_w'(repeat_cycles - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rep_cnt <= '0;
    else if (wrap)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  // One strobe per interval while held
  assign up_pulse    = wrap & ~key_sync.speed_up_n;
  assign down_pulse  = wrap & ~key_sync.speed_down_n;
  assign reset_pulse = ~key_sync.speed_reset_n;

endmodule

`default_nettype wire

// ==== design/sample_rate_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_rate_ctrl (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  logic                   up_pulse,
  input  logic                   down_pulse,
  input  logic                   reset_pulse,
  output organ_pkg::rate_count_t rate_count
);

  typedef enum logic [1:0] {
    op_hold,
    op_up,
    op_down,
    op_clear
  } step_op_e;

  step_op_e          op;
  organ_pkg::speed_t speed;

  // Reset key first; up and down together cancel
  always_comb
  begin
    if (reset_pulse)
      op = op_clear;
    else if (up_pulse && !down_pulse)
      op = op_up;
    else if (down_pulse && !up_pulse)
      op = op_down;
    else
      op = op_hold;
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      speed      <= '0;
      rate_count <= organ_pkg::default_rate_count;
    end
    else
    begin
      case (op)
        op_clear: speed <= '0;
        op_up:    speed <= speed + organ_pkg::speed_step;
        op_down:  speed <= speed - organ_pkg::speed_step;
        default:  speed <= speed;
      endcase
      // Wraps modulo 2^16 in both directions
      rate_count <= organ_pkg::default_rate_count + organ_pkg::rate_count_t'(speed);
    end
  end

endmodule

`default_nettype wire

// ==== design/seg7_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module seg7_display #(
  parameter int refresh_cycles = 25_000_000
) (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  organ_pkg::rate_count_t rate_count,
  output organ_pkg::hex_bank_t   hex
);

  localparam int cnt_w = (refresh_cycles > 1) ? $clog2(refresh_cycles) : 1;

  logic [cnt_w-1:0] refresh_cnt;
  logic             tick;
  logic [23:0]      shown;

  // ==========================================================
  // Slow refresh of the displayed value
  // ==========================================================

  assign tick = (refresh_cnt == cnt_w'(refresh_cycles - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
      shown       <= '0;
    end
    else if (tick)
    begin
      refresh_cnt <= '0;
      shown       <= {8'h00, rate_count};
    end
    else
    begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Digit 0 is the low nibble
  assign hex = '{
    hex5: organ_pkg::seg7_glyph[shown[23:20]],
    hex4: organ_pkg::seg7_glyph[shown[19:16]],
    hex3: organ_pkg::seg7_glyph[shown[15:12]],
    hex2: organ_pkg::seg7_glyph[shown[11:8]],
    hex1: organ_pkg::seg7_glyph[shown[7:4]],
    hex0: organ_pkg::seg7_glyph[shown[3:0]]
  };

endmodule

`default_nettype wire

// ==== design/organ_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module organ_top #(
  parameter int clk_hz         = 50_000_000,
  parameter int repeat_cycles  = 5_000_000,
  parameter int refresh_cycles = 25_000_000
) (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  organ_pkg::organ_sw_t   sw,
  input  organ_pkg::key_n_t      key_n,
  output organ_pkg::audio_t      audio,
  output organ_pkg::text4_t      note_text,
  output organ_pkg::text4_t      power_text,
  output organ_pkg::rate_count_t rate_count,
  output organ_pkg::hex_bank_t   hex
);

  logic [31:0] half_period;
  logic        power;
  logic        up_pulse;
  logic        down_pulse;
  logic        reset_pulse;

  // ==========================================================
  // Note chain
  // ==========================================================

  note_select #(
    .clk_hz(clk_hz)
  ) u_note_select (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .sw         (sw),
    .half_period(half_period),
    .power      (power),
    .note_text  (note_text),
    .power_text (power_text)
  );

  tone_gen u_tone_gen (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .half_period(half_period),
    .power      (power),
    .audio      (audio)
  );

  // ==========================================================
  // Speed chain
  // ==========================================================

  key_repeat #(
    .repeat_cycles(repeat_cycles)
  ) u_key_repeat (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .key_n      (key_n),
    .up_pulse   (up_pulse),
    .down_pulse (down_pulse),
    .reset_pulse(reset_pulse)
  );

  sample_rate_ctrl u_sample_rate_ctrl (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .up_pulse   (up_pulse),
    .down_pulse (down_pulse),
    .reset_pulse(reset_pulse),
    .rate_count (rate_count)
  );

  seg7_display #(
    .refresh_cycles(refresh_cycles)
  ) u_seg7_display (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .rate_count(rate_count),
    .hex       (hex)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int half_period_ns = 10,
  parameter int reset_cycles   = 8
) (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial
  begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/organ_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module organ_assert (
  input logic              CLK_50M,
  input logic              arst_n,
  input organ_pkg::audio_t audio,
  input logic              power,
  input logic              up_pulse
);

  // ==========================================================
  // Audio levels
  // ==========================================================

  a_audio_levels: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (audio == 8'sh7F) || (audio == 8'sh80))
    else $error("audio sample is neither the high nor the low level");

  // Wave held low while off, so still silent on the cycle after
  a_power_off_low: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    !power |=> (audio == 8'sh80))
    else $error("audio left the low level right after power was off");

  // ==========================================================
  // Key repeat strobes
  // ==========================================================

  a_up_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    up_pulse |=> !up_pulse)
    else $error("up_pulse stayed high for two cycles");

endmodule

bind organ_top organ_assert u_organ_assert (
  .CLK_50M (CLK_50M),
  .arst_n  (arst_n),
  .audio   (audio),
  .power   (power),
  .up_pulse(up_pulse)
);

`default_nettype wire

// ==== testbench/tb_organ.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_organ;

  localparam int tb_clk_hz         = 100_000;
  localparam int tb_repeat_cycles  = 64;
  localparam int tb_refresh_cycles = 200;

  localparam int n_note_trials   = 16;
  localparam int n_tone_trials   = 8;
  localparam int n_spans         = 12;
  localparam int max_span        = 300;
  localparam int off_cycles      = 200;
  localparam int toggle_wait     = 200;
  localparam int long_down_wraps = 130;

  // Test lengths in cycles summed for the run limit
  localparam int note_len    = n_note_trials * 3;
  localparam int tone_len    = n_tone_trials * (4 + 6 * 96) + 4 + off_cycles;
  localparam int key_len     = n_spans * (max_span + 4) + 14
                               + long_down_wraps * tb_repeat_cycles + 4;
  localparam int reset_len   = 3 * tb_repeat_cycles + 2 * 100 + 8;
  localparam int display_len = 3 * tb_repeat_cycles + tb_refresh_cycles + 8;
  localparam int test_cycles = note_len + tone_len + key_len + reset_len + display_len;
  localparam int timeout_cycles = test_cycles + test_cycles / 2 + 2000;

  localparam organ_pkg::rate_count_t base_rate = 16'd12499;

  logic                   clk;
  logic                   arst_n;
  organ_pkg::organ_sw_t   sw;
  organ_pkg::key_n_t      key_n;
  organ_pkg::audio_t      audio;
  organ_pkg::text4_t      note_text;
  organ_pkg::text4_t      power_text;
  organ_pkg::rate_count_t rate_count;
  organ_pkg::hex_bank_t   hex;

  logic [31:0] rng_state = 32'h8126;
  int          err_value;
  int          err_other;
  int          cycle_count;
  string       test_name;

  // Model state of the key and display chain
  organ_pkg::key_n_t      key_s1;
  organ_pkg::key_n_t      key_s2;
  int                     rep_cnt_m;
  int                     ref_cnt_m;
  organ_pkg::speed_t      speed_m;
  organ_pkg::rate_count_t rate_m;
  logic [23:0]            shown_m;

  tb_clock_gen #(
    .half_period_ns(10),
    .reset_cycles  (8)
  ) u_clock_gen (
    .clk   (clk),
    .arst_n(arst_n)
  );

  organ_top #(
    .clk_hz        (tb_clk_hz),
    .repeat_cycles (tb_repeat_cycles),
    .refresh_cycles(tb_refresh_cycles)
  ) dut (
    .CLK_50M   (clk),
    .arst_n    (arst_n),
    .sw        (sw),
    .key_n     (key_n),
    .audio     (audio),
    .note_text (note_text),
    .power_text(power_text),
    .rate_count(rate_count),
    .hex       (hex)
  );

  // ==========================================================
  // Reference tables and random numbers
  // ==========================================================

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Switch order of the board
  function automatic int note_of_code(input logic [2:0] code);
    case (code)
      3'b000:  return 0;
      3'b001:  return 1;
      3'b010:  return 2;
      3'b100:  return 3;
      3'b011:  return 4;
      3'b101:  return 5;
      3'b110:  return 6;
      default: return 7;
    endcase
  endfunction

  // Half periods in cycles at the testbench clock rate
  function automatic logic [31:0] expected_half(input int n);
    case (n)
      0:       return 32'd95;
      1:       return 32'd85;
      2:       return 32'd75;
      3:       return 32'd71;
      4:       return 32'd63;
      5:       return 32'd56;
      6:       return 32'd50;
      default: return 32'd47;
    endcase
  endfunction

  function automatic string note_name_str(input int n);
    case (n)
      0:       return "DO  ";
      1:       return "RE  ";
      2:       return "MI  ";
      3:       return "FA  ";
      4:       return "SO  ";
      5:       return "LA  ";
      6:       return "SI  ";
      default: return "DOH ";
    endcase
  endfunction

  function automatic organ_pkg::text4_t text_of(input string s);
    organ_pkg::text4_t t;
    t.c0 = s[0];
    t.c1 = s[1];
    t.c2 = s[2];
    t.c3 = s[3];
    return t;
  endfunction

  function automatic organ_pkg::seg7_t glyph(input logic [3:0] v);
    case (v)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic organ_pkg::hex_bank_t hex_of(input logic [23:0] v);
    organ_pkg::hex_bank_t h;
    h.hex5 = glyph(v[23:20]);
    h.hex4 = glyph(v[19:16]);
    h.hex3 = glyph(v[15:12]);
    h.hex2 = glyph(v[11:8]);
    h.hex1 = glyph(v[7:4]);
    h.hex0 = glyph(v[3:0]);
    return h;
  endfunction

  // ==========================================================
  // Compare tasks
  // ==========================================================

  task automatic check_audio(input string name, input organ_pkg::audio_t exp,
                             input organ_pkg::audio_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERROR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_text(input string name, input organ_pkg::text4_t exp,
                            input organ_pkg::text4_t act);
    logic [31:0] e;
    logic [31:0] a;
    e = exp;
    a = act;
    if (a !== e)
    begin
      err_value++;
      $display("ERROR %s: expected \"%s\" (%h) actual \"%s\" (%h)", name, e, e, a, a);
    end
  endtask

  task automatic check_count(input string name, input organ_pkg::rate_count_t exp,
                             input organ_pkg::rate_count_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERROR %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_hex(input string name, input organ_pkg::hex_bank_t exp,
                           input organ_pkg::hex_bank_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERROR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_period(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERROR %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // ==========================================================
  // Cycle stepping with the key and display model
  // ==========================================================

  task automatic update_model();
    logic                   up_p;
    logic                   down_p;
    logic                   rst_p;
    organ_pkg::rate_count_t rate_next;
    up_p   = (rep_cnt_m == tb_repeat_cycles - 1) && !key_s2.speed_up_n;
    down_p = (rep_cnt_m == tb_repeat_cycles - 1) && !key_s2.speed_down_n;
    rst_p  = !key_s2.speed_reset_n;
    // Display latches the count as it stood before this edge
    if (ref_cnt_m == tb_refresh_cycles - 1)
    begin
      shown_m   = {8'h00, rate_m};
      ref_cnt_m = 0;
    end
    else
      ref_cnt_m++;
    rate_next = base_rate + organ_pkg::rate_count_t'(speed_m);
    if (rst_p)
      speed_m = '0;
    else if (up_p && !down_p)
      speed_m = speed_m + 16'sd100;
    else if (down_p && !up_p)
      speed_m = speed_m - 16'sd100;
    rate_m    = rate_next;
    rep_cnt_m = (rep_cnt_m == tb_repeat_cycles - 1) ? 0 : rep_cnt_m + 1;
    key_s2    = key_s1;
    key_s1    = key_n;
  endtask

  // Count and display checked on every falling edge
  task automatic run_cycle();
    @(posedge clk);
    update_model();
    @(negedge clk);
    check_count(test_name, rate_m, rate_count);
    check_hex(test_name, hex_of(shown_m), hex);
  endtask

  task automatic set_keys(input logic up, input logic down, input logic rst);
    key_n.speed_up_n    = ~up;
    key_n.speed_down_n  = ~down;
    key_n.speed_reset_n = ~rst;
  endtask

  task automatic wait_toggle(output int n, output bit ok);
    organ_pkg::audio_t start_level;
    start_level = audio;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < toggle_wait)
    begin
      run_cycle();
      n++;
      if (audio !== start_level)
        ok = 1'b1;
    end
    if (!ok)
    begin
      err_other++;
      $display("audio did not change level within %0d cycles in test %s", toggle_wait, test_name);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles)
    begin
      $display("Run stopped: still going after %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Test sequence
  // ==========================================================

  initial
  begin
    int                i;
    int                j;
    int                n;
    int                span;
    bit                ok;
    bit                saw_wrap;
    logic [31:0]       rnd;
    logic [2:0]        code;
    logic              pwr;
    organ_pkg::text4_t exp_note;
    organ_pkg::text4_t exp_power;
    organ_pkg::text4_t prev_note;
    organ_pkg::text4_t prev_power;
    organ_pkg::rate_count_t prev_rate;

    sw          = '0;
    key_n       = '1;
    err_value   = 0;
    err_other   = 0;
    key_s1      = '1;
    key_s2      = '1;
    rep_cnt_m   = 0;
    ref_cnt_m   = 0;
    speed_m     = '0;
    rate_m      = base_rate;
    shown_m     = '0;

    @(posedge arst_n);
    test_name = "reset";
    check_count(test_name, base_rate, rate_count);
    check_hex(test_name, hex_of(24'h000000), hex);
    check_audio(test_name, 8'h80, audio);
    check_text(test_name, text_of("OFF "), power_text);
    check_text(test_name, text_of("    "), note_text);

    // Note text with the old value held for two edges
    test_name  = "notes";
    prev_note  = text_of("    ");
    prev_power = text_of("OFF ");
    for (i = 0; i < n_note_trials; i++)
    begin
      rnd       = next_random();
      code      = rnd[2:0];
      pwr       = (i % 4 != 3);
      exp_note  = pwr ? text_of(note_name_str(note_of_code(code))) : text_of("    ");
      exp_power = pwr ? text_of("ON  ") : text_of("OFF ");
      sw.power     = pwr;
      sw.note_code = code;
      repeat (2) run_cycle();
      check_text("notes_hold", prev_note, note_text);
      check_text("notes_hold", prev_power, power_text);
      run_cycle();
      check_text("notes", exp_note, note_text);
      check_text("notes", exp_power, power_text);
      prev_note  = exp_note;
      prev_power = exp_power;
    end

    // Tone period after skipping the first partial interval
    test_name = "tone";
    for (i = 0; i < n_tone_trials; i++)
    begin
      rnd          = next_random();
      code         = rnd[2:0];
      sw.power     = 1'b1;
      sw.note_code = code;
      repeat (4) run_cycle();
      wait_toggle(n, ok);
      for (j = 0; j < 4 && ok; j++)
      begin
        wait_toggle(n, ok);
        if (ok)
          check_period("tone", expected_half(note_of_code(code)), 32'(n));
      end
    end
    sw.power = 1'b0;
    repeat (4) run_cycle();
    for (i = 0; i < off_cycles; i++)
    begin
      run_cycle();
      check_audio("tone_off", 8'h80, audio);
    end

    // Held keys over random spans
    test_name = "speed_keys";
    for (i = 0; i < n_spans; i++)
    begin
      rnd  = next_random();
      span = 20 + int'(next_random() % 32'd281);
      case (rnd % 32'd3)
        32'd0:   set_keys(1'b1, 1'b0, 1'b0);
        32'd1:   set_keys(1'b0, 1'b1, 1'b0);
        default: set_keys(1'b1, 1'b1, 1'b0);
      endcase
      repeat (span) run_cycle();
      set_keys(1'b0, 1'b0, 1'b0);
      repeat (4) run_cycle();
    end

    // A long down hold from zero speed runs the count below zero
    test_name = "speed_wrap";
    set_keys(1'b0, 1'b0, 1'b1);
    repeat (10) run_cycle();
    set_keys(1'b0, 1'b1, 1'b0);
    saw_wrap = 1'b0;
    for (i = 0; i < long_down_wraps * tb_repeat_cycles; i++)
    begin
      prev_rate = rate_m;
      run_cycle();
      if (rate_m > prev_rate)
        saw_wrap = 1'b1;
    end
    set_keys(1'b0, 1'b0, 1'b0);
    repeat (4) run_cycle();
    if (!saw_wrap)
    begin
      err_other++;
      $display("The long down hold never carried rate_count past zero");
    end

    // Reset key wins over held up and down
    test_name = "speed_reset";
    set_keys(1'b1, 1'b0, 1'b0);
    repeat (3 * tb_repeat_cycles) run_cycle();
    set_keys(1'b1, 1'b0, 1'b1);
    repeat (100) run_cycle();
    check_count("speed_reset", base_rate, rate_count);
    set_keys(1'b1, 1'b1, 1'b1);
    repeat (100) run_cycle();
    check_count("speed_reset", base_rate, rate_count);
    set_keys(1'b0, 1'b0, 1'b0);
    repeat (8) run_cycle();

    test_name = "display";
    set_keys(1'b0, 1'b1, 1'b0);
    repeat (3 * tb_repeat_cycles) run_cycle();
    set_keys(1'b0, 1'b0, 1'b0);
    repeat (tb_refresh_cycles + 8) run_cycle();
    check_hex("display", hex_of({8'h00, rate_m}), hex);

    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/organ_pkg.sv
design/note_select.sv
design/tone_gen.sv
design/key_repeat.sv
design/sample_rate_ctrl.sv
design/seg7_display.sv
design/organ_top.sv
testbench/tb_clock_gen.sv
testbench/organ_assert.sv
testbench/tb_organ.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_organ -o tb_organ_sim

result=$(./obj_dir/tb_organ_sim)
echo "$result"

if echo "$result" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
